/* src/adres_haritasi_pkg.sv */
// Data bus address map
package adres_haritasi_pkg;

    // Region select bits of the data bus address.
    localparam int L1V_BIT = 30;
    localparam int VY_BIT  = 29;
    localparam int TMR_BIT = 28;

    // Target of a single data bus access.
    typedef enum logic [1:0] {
        BOLGE_YOK = 2'd0,
        BOLGE_L1V = 2'd1,
        BOLGE_VY  = 2'd2,
        BOLGE_TMR = 2'd3
    } bolge_t;

    // Scratchpad geometry.
    localparam int L1V_KELIME = 256;
    localparam int L1V_ADR_W  = 8;
    localparam int L1V_ADR_LSB = 2; // Word index starts above the byte offset.

endpackage

/* src/cevre_pkg.sv */
// Timer and PWM register map
package cevre_pkg;

    localparam int OFS_W = 4; // Byte offset width inside a peripheral.

    // Timer words.
    localparam int TMR_W = 64;
    localparam logic [OFS_W-1:0] TMR_ALT_OFS = 4'h0;
    localparam logic [OFS_W-1:0] TMR_UST_OFS = 4'h4;

    // PWM registers.
    localparam int PWM_W = 16;
    localparam logic [OFS_W-1:0] PWM_PERIYOT_OFS  = 4'h0;
    localparam logic [OFS_W-1:0] PWM_DOLULUK0_OFS = 4'h4;
    localparam logic [OFS_W-1:0] PWM_DOLULUK1_OFS = 4'h8;

endpackage

/* src/bib_yonlendirici.sv */
// Data bus router
`timescale 1ns/1ps

module bib_yonlendirici (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] bib_adr_i,
    input  logic        bib_sec_i,
    input  logic [31:0] l1v_oku_veri_i,
    input  logic        l1v_durdur_i,
    input  logic [31:0] vy_oku_veri_i,
    input  logic        vy_durdur_i,
    input  logic [31:0] tmr_oku_veri_i,
    output logic        l1v_sec_o,
    output logic        vy_sec_o,
    output logic        tmr_sec_o,
    output logic [31:0] bib_oku_veri_o,
    output logic        bib_durdur_o
);

    adres_haritasi_pkg::bolge_t bolge;       // Decoded from the live address.
    adres_haritasi_pkg::bolge_t bolge_q;     // Region of a stalled access.
    adres_haritasi_pkg::bolge_t bolge_sonuc; // Drives the result mux.

    // Scratchpad wins over timer, timer over peripherals.
    always_comb begin
        if (bib_adr_i[adres_haritasi_pkg::L1V_BIT]) begin
            bolge = adres_haritasi_pkg::BOLGE_L1V;
        end else if (bib_adr_i[adres_haritasi_pkg::TMR_BIT]) begin
            bolge = adres_haritasi_pkg::BOLGE_TMR;
        end else if (bib_adr_i[adres_haritasi_pkg::VY_BIT]) begin
            bolge = adres_haritasi_pkg::BOLGE_VY;
        end else begin
            bolge = adres_haritasi_pkg::BOLGE_YOK;
        end
    end

    assign l1v_sec_o = bib_sec_i && (bolge == adres_haritasi_pkg::BOLGE_L1V);
    assign vy_sec_o  = bib_sec_i && (bolge == adres_haritasi_pkg::BOLGE_VY);
    assign tmr_sec_o = bib_sec_i && (bolge == adres_haritasi_pkg::BOLGE_TMR);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bolge_q <= adres_haritasi_pkg::BOLGE_YOK;
        end else if (bib_durdur_o) begin
            bolge_q <= bolge_sonuc; // Keep the waiting target.
        end else begin
            bolge_q <= adres_haritasi_pkg::BOLGE_YOK;
        end
    end

    assign bolge_sonuc = (bolge_q != adres_haritasi_pkg::BOLGE_YOK) ? bolge_q : bolge;

    always_comb begin
        case (bolge_sonuc)
            adres_haritasi_pkg::BOLGE_L1V: begin
                bib_oku_veri_o = l1v_oku_veri_i;
                bib_durdur_o   = l1v_durdur_i;
            end
            adres_haritasi_pkg::BOLGE_VY: begin
                bib_oku_veri_o = vy_oku_veri_i;
                bib_durdur_o   = vy_durdur_i;
            end
            adres_haritasi_pkg::BOLGE_TMR: begin
                bib_oku_veri_o = tmr_oku_veri_i;
                bib_durdur_o   = 1'b0; // Timer never stalls.
            end
            default: begin
                bib_oku_veri_o = 32'h0000_0000; // Unmapped reads zero.
                bib_durdur_o   = 1'b0;
            end
        endcase
    end

endmodule

/* src/veri_bellegi.sv */
// Data scratchpad
`timescale 1ns/1ps

module veri_bellegi (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     l1v_sec_i,
    input  logic [adres_haritasi_pkg::L1V_ADR_W-1:0] l1v_adr_i,
    input  logic [31:0]                              l1v_veri_i,
    input  logic [3:0]                               l1v_maske_i,
    output logic [31:0]                              l1v_oku_veri_o,
    output logic                                     l1v_durdur_o
);

    logic [31:0] bellek [adres_haritasi_pkg::L1V_KELIME];
    logic [31:0] oku_q;
    logic        bekle_q; // Read word is in oku_q.
    logic        yaz;
    logic        oku;

    assign yaz = l1v_sec_i && (l1v_maske_i != 4'b0000);
    assign oku = l1v_sec_i && (l1v_maske_i == 4'b0000);

    // Byte lanes follow the mask.
    always_ff @(posedge clk) begin
        if (yaz) begin
            for (int b = 0; b < 4; b++) begin
                if (l1v_maske_i[b]) begin
                    bellek[l1v_adr_i][8*b +: 8] <= l1v_veri_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (oku && !bekle_q) begin
            oku_q <= bellek[l1v_adr_i];
        end
    end

    // Set on the first read cycle, cleared on completion.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bekle_q <= 1'b0;
        end else begin
            bekle_q <= oku && !bekle_q;
        end
    end

    assign l1v_durdur_o   = oku && !bekle_q;
    assign l1v_oku_veri_o = oku_q;

endmodule

/* src/zamanlayici.sv */
// Free-running cycle timer
`timescale 1ns/1ps

module zamanlayici (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        tmr_sec_i,
    input  logic [2:2]  tmr_adr_i,
    output logic [31:0] tmr_oku_veri_o
);

    logic [cevre_pkg::TMR_W-1:0] sayac_q;
    logic [cevre_pkg::OFS_W-1:0] ofs;
    logic [31:0]                 kelime;

    // Counts rising edges since reset release.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sayac_q <= '0;
        end else begin
            sayac_q <= sayac_q + 1'b1;
        end
    end

    assign ofs = {1'b0, tmr_adr_i, 2'b00};

    always_comb begin
        case (ofs)
            cevre_pkg::TMR_ALT_OFS: kelime = sayac_q[31:0];
            cevre_pkg::TMR_UST_OFS: kelime = sayac_q[63:32];
            default:                kelime = 32'h0000_0000;
        endcase
    end

    // No write path.
    assign tmr_oku_veri_o = tmr_sec_i ? kelime : 32'h0000_0000;

endmodule

/* src/darbe_genislik.sv */
// Two-channel PWM peripheral
`timescale 1ns/1ps

module darbe_genislik (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        vy_sec_i,
    input  logic [3:2]  vy_adr_i,
    input  logic [31:0] vy_veri_i,
    input  logic [3:0]  vy_maske_i,
    output logic [31:0] vy_oku_veri_o,
    output logic        vy_durdur_o,
    output logic        pwm0_o,
    output logic        pwm1_o
);

    logic [cevre_pkg::PWM_W-1:0] periyot_q;
    logic [cevre_pkg::PWM_W-1:0] doluluk0_q;
    logic [cevre_pkg::PWM_W-1:0] doluluk1_q;
    logic [cevre_pkg::PWM_W-1:0] sayac_q;
    logic [cevre_pkg::OFS_W-1:0] ofs;
    logic                        bekle_q;
    logic                        yaz;

    function automatic logic [cevre_pkg::PWM_W-1:0] maskeli_yaz(
        input logic [cevre_pkg::PWM_W-1:0] eski,
        input logic [31:0]                 veri,
        input logic [3:0]                  maske
    );
        logic [cevre_pkg::PWM_W-1:0] yeni;
        yeni = eski;
        for (int b = 0; b < cevre_pkg::PWM_W / 8; b++) begin
            if (maske[b]) begin
                yeni[8*b +: 8] = veri[8*b +: 8];
            end
        end
        return yeni;
    endfunction

    assign ofs         = {vy_adr_i, 2'b00};
    assign vy_durdur_o = vy_sec_i && !bekle_q;
    assign yaz         = vy_sec_i && bekle_q && (vy_maske_i != 4'b0000); // Completion edge.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bekle_q    <= 1'b0;
            periyot_q  <= '0;
            doluluk0_q <= '0;
            doluluk1_q <= '0;
        end else begin
            bekle_q <= vy_sec_i && !bekle_q;
            if (yaz && ofs == cevre_pkg::PWM_PERIYOT_OFS) begin
                periyot_q <= maskeli_yaz(periyot_q, vy_veri_i, vy_maske_i);
            end
            if (yaz && ofs == cevre_pkg::PWM_DOLULUK0_OFS) begin
                doluluk0_q <= maskeli_yaz(doluluk0_q, vy_veri_i, vy_maske_i);
            end
            if (yaz && ofs == cevre_pkg::PWM_DOLULUK1_OFS) begin
                doluluk1_q <= maskeli_yaz(doluluk1_q, vy_veri_i, vy_maske_i);
            end
        end
    end

    always_comb begin
        case (ofs)
            cevre_pkg::PWM_PERIYOT_OFS:  vy_oku_veri_o = 32'(periyot_q);
            cevre_pkg::PWM_DOLULUK0_OFS: vy_oku_veri_o = 32'(doluluk0_q);
            cevre_pkg::PWM_DOLULUK1_OFS: vy_oku_veri_o = 32'(doluluk1_q);
            default:                     vy_oku_veri_o = 32'h0000_0000;
        endcase
    end

    // Shared counter and registered compares.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sayac_q <= '0;
            pwm0_o  <= 1'b0;
            pwm1_o  <= 1'b0;
        end else begin
            if (periyot_q == '0 || sayac_q >= periyot_q - 1'b1) begin
                sayac_q <= '0; // Also catches a shrunk period.
            end else begin
                sayac_q <= sayac_q + 1'b1;
            end
            pwm0_o <= sayac_q < doluluk0_q;
            pwm1_o <= sayac_q < doluluk1_q;
        end
    end

endmodule

/* src/cekirdek_ramsiz.sv */
// RAM-less core data side
`timescale 1ns/1ps

module cekirdek_ramsiz (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] bib_adr_i,
    input  logic [31:0] bib_veri_i,
    input  logic [3:0]  bib_maske_i,
    input  logic        bib_sec_i,
    output logic [31:0] bib_oku_veri_o,
    output logic        bib_durdur_o,
    output logic        pwm0_o,
    output logic        pwm1_o
);

    logic [31:0] l1v_oku_veri;
    logic        l1v_sec;
    logic        l1v_durdur;

    logic [31:0] vy_oku_veri;
    logic        vy_sec;
    logic        vy_durdur;

    logic [31:0] tmr_oku_veri;
    logic        tmr_sec;

    bib_yonlendirici bib_yonlendirici0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .bib_adr_i      (bib_adr_i),
        .bib_sec_i      (bib_sec_i),
        .l1v_oku_veri_i (l1v_oku_veri),
        .l1v_durdur_i   (l1v_durdur),
        .vy_oku_veri_i  (vy_oku_veri),
        .vy_durdur_i    (vy_durdur),
        .tmr_oku_veri_i (tmr_oku_veri),
        .l1v_sec_o      (l1v_sec),
        .vy_sec_o       (vy_sec),
        .tmr_sec_o      (tmr_sec),
        .bib_oku_veri_o (bib_oku_veri_o),
        .bib_durdur_o   (bib_durdur_o)
    );

    veri_bellegi veri_bellegi0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .l1v_sec_i      (l1v_sec),
        .l1v_adr_i      (bib_adr_i[adres_haritasi_pkg::L1V_ADR_LSB +:
                                   adres_haritasi_pkg::L1V_ADR_W]), // Bits 9..2.
        .l1v_veri_i     (bib_veri_i),
        .l1v_maske_i    (bib_maske_i),
        .l1v_oku_veri_o (l1v_oku_veri),
        .l1v_durdur_o   (l1v_durdur)
    );

    zamanlayici zamanlayici0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .tmr_sec_i      (tmr_sec),
        .tmr_adr_i      (bib_adr_i[2:2]),
        .tmr_oku_veri_o (tmr_oku_veri)
    );

    darbe_genislik darbe_genislik0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .vy_sec_i      (vy_sec),
        .vy_adr_i      (bib_adr_i[3:2]),
        .vy_veri_i     (bib_veri_i),
        .vy_maske_i    (bib_maske_i),
        .vy_oku_veri_o (vy_oku_veri),
        .vy_durdur_o   (vy_durdur),
        .pwm0_o        (pwm0_o),
        .pwm1_o        (pwm1_o)
    );

endmodule

/* bench/bib_chk.sv */
// Data bus router assertions
`timescale 1ns/1ps

module bib_chk (
    input logic clk,
    input logic rst_n_i,
    input logic bib_sec_i,
    input logic l1v_sec_i,
    input logic vy_sec_i,
    input logic tmr_sec_i,
    input logic bib_durdur_i
);

    int ihlal_say = 0; // Failed assertions so far.

    tek_hedef: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({l1v_sec_i, vy_sec_i, tmr_sec_i}))
    else begin
        $error("more than one target select is high");
        ihlal_say++;
    end

    kisa_durdur: assert property (@(posedge clk) disable iff (!rst_n_i)
        bib_durdur_i |=> !bib_durdur_i)
    else begin
        $error("stall held high for two cycles");
        ihlal_say++;
    end

    secsiz_hedef: assert property (@(posedge clk) disable iff (!rst_n_i)
        !bib_sec_i |-> !(l1v_sec_i || vy_sec_i || tmr_sec_i))
    else begin
        $error("target selected while the bus is idle");
        ihlal_say++;
    end

endmodule

bind bib_yonlendirici bib_chk bib_chk0 (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .bib_sec_i    (bib_sec_i),
    .l1v_sec_i    (l1v_sec_o),
    .vy_sec_i     (vy_sec_o),
    .tmr_sec_i    (tmr_sec_o),
    .bib_durdur_i (bib_durdur_o)
);

/* bench/tb_cekirdek_ramsiz.sv */
// RAM-less core testbench
`timescale 1ns/1ps

module tb_cekirdek_ramsiz;

    localparam int PERIYOT_NS = 40;
    localparam int SURUS_NS   = 2;
    localparam int PWM_P      = 10;
    localparam int ERISIM_SAY = 128 + 5 + 10 + 3 + 9;       // Accesses over all tests.
    localparam int BEKLEME    = 20 + 13 + 3 * PWM_P + 6 * 2; // Idle and settle cycles.
    localparam int SINIR      = 3 * ERISIM_SAY + BEKLEME + 100;
    localparam logic [31:0] L1V_TABAN = 32'h4000_0000;
    localparam logic [31:0] VY_TABAN  = 32'h2000_0000;
    localparam logic [31:0] TMR_TABAN = 32'h1000_0000;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] bib_adr_i;
    logic [31:0] bib_veri_i;
    logic [3:0]  bib_maske_i;
    logic        bib_sec_i;
    logic [31:0] bib_oku_veri_o;
    logic        bib_durdur_o;
    logic        pwm0_o;
    logic        pwm1_o;

    logic [31:0] golge_l1v [256];
    bit          yazildi [256];
    logic [15:0] golge_pwm [3];
    logic [63:0] cevrim;
    int          hata_say = 0;
    int          hata_basi = 0;
    int          kontrol_say = 0;
    logic [31:0] kuyruk_adr [$];
    logic [31:0] kuyruk_bek [$];
    logic [31:0] kuyruk_gel [$];

    cekirdek_ramsiz dut0 (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .bib_adr_i      (bib_adr_i),
        .bib_veri_i     (bib_veri_i),
        .bib_maske_i    (bib_maske_i),
        .bib_sec_i      (bib_sec_i),
        .bib_oku_veri_o (bib_oku_veri_o),
        .bib_durdur_o   (bib_durdur_o),
        .pwm0_o         (pwm0_o),
        .pwm1_o         (pwm1_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIYOT_NS / 2) clk = ~clk;
    end

    // Rising edges since reset release.
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cevrim <= '0;
        end else begin
            cevrim <= cevrim + 64'd1;
        end
    end

    // Expected read word by region priority.
    function automatic logic [31:0] beklenen_oku(input logic [31:0] adr);
        if (adr[adres_haritasi_pkg::L1V_BIT]) begin
            return golge_l1v[adr[9:2]];
        end
        if (adr[adres_haritasi_pkg::TMR_BIT]) begin
            return adr[2] ? cevrim[63:32] : cevrim[31:0];
        end
        if (adr[adres_haritasi_pkg::VY_BIT] && adr[3:2] != 2'd3) begin
            return {16'h0000, golge_pwm[adr[3:2]]};
        end
        return 32'h0000_0000;
    endfunction

    function automatic int beklenen_durdur(input logic [31:0] adr, input logic [3:0] maske);
        if (adr[adres_haritasi_pkg::L1V_BIT]) begin
            return (maske == 4'b0000) ? 1 : 0; // Only reads wait.
        end
        if (adr[adres_haritasi_pkg::TMR_BIT]) begin
            return 0;
        end
        if (adr[adres_haritasi_pkg::VY_BIT]) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic golge_yaz(input logic [31:0] adr, input logic [31:0] veri,
                             input logic [3:0] maske);
        if (adr[adres_haritasi_pkg::L1V_BIT]) begin
            for (int b = 0; b < 4; b++) begin
                if (maske[b]) golge_l1v[adr[9:2]][8*b +: 8] = veri[8*b +: 8];
            end
        end else if (!adr[adres_haritasi_pkg::TMR_BIT] && adr[adres_haritasi_pkg::VY_BIT]
                     && adr[3:2] != 2'd3) begin
            for (int b = 0; b < 2; b++) begin
                if (maske[b]) golge_pwm[adr[3:2]][8*b +: 8] = veri[8*b +: 8];
            end
        end
    endtask

    // One bus access, started 2 ns after a rising edge.
    task automatic erisim(input logic [31:0] adr, input logic [31:0] veri,
                          input logic [3:0] maske);
        int durdur;
        bit bitti;
        durdur = 0;
        bitti = 1'b0;
        bib_adr_i = adr;
        bib_veri_i = veri;
        bib_maske_i = maske;
        bib_sec_i = 1'b1;
        while (!bitti) begin
            @(negedge clk);
            if (bib_durdur_o) begin
                durdur++;
                @(posedge clk);
                #(SURUS_NS);
            end else begin
                bitti = 1'b1;
            end
        end
        if (maske == 4'b0000) begin
            kuyruk_adr.push_back(adr);
            kuyruk_bek.push_back(beklenen_oku(adr));
            kuyruk_gel.push_back(bib_oku_veri_o);
        end
        kontrol_say++;
        if (durdur != beklenen_durdur(adr, maske)) begin
            hata_say++;
            $display("** Error at %0t: %0d stall cycles at address %h, expected %0d",
                     $time, durdur, adr, beklenen_durdur(adr, maske));
        end
        @(posedge clk);
        #(SURUS_NS);
        bib_sec_i = 1'b0;
        golge_yaz(adr, veri, maske);
    endtask

    task automatic yaz(input logic [31:0] adr, input logic [31:0] veri, input logic [3:0] maske);
        erisim(adr, veri, maske);
    endtask

    task automatic oku(input logic [31:0] adr);
        erisim(adr, 32'h0000_0000, 4'b0000);
    endtask

    // Counts high cycles of both outputs over n cycles.
    task automatic pwm_olc(input int n, input int bek0, input int bek1);
        int yuksek0;
        int yuksek1;
        yuksek0 = 0;
        yuksek1 = 0;
        repeat (n) begin
            @(negedge clk);
            if (pwm0_o) yuksek0++;
            if (pwm1_o) yuksek1++;
        end
        kontrol_say++;
        if (yuksek0 != bek0 || yuksek1 != bek1) begin
            hata_say++;
            $display("** Error at %0t: PWM high counts %0d/%0d, expected %0d/%0d",
                     $time, yuksek0, yuksek1, bek0, bek1);
        end
        @(posedge clk);
        #(SURUS_NS);
    endtask

    task automatic test_bitir(input string ad);
        repeat (2) @(posedge clk);
        #(SURUS_NS);
        $display("test %s: %0d errors", ad, hata_say - hata_basi);
        hata_basi = hata_say;
    endtask

    always @(posedge clk) begin
        logic [31:0] adr;
        logic [31:0] bek;
        logic [31:0] gel;
        while (kuyruk_adr.size() > 0) begin
            adr = kuyruk_adr.pop_front();
            bek = kuyruk_bek.pop_front();
            gel = kuyruk_gel.pop_front();
            kontrol_say++;
            if (gel !== bek) begin
                hata_say++;
                $display("** Error at %0t: read %h expected %h got %h", $time, adr, bek, gel);
            end
        end
    end

    initial begin
        while (cevrim !== 64'(SINIR)) @(posedge clk);
        $display("Run stopped: %0d cycles passed and the tests had not ended.", SINIR);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int         idx;
        int         bek0;
        int         bek1;
        int         ihlal;
        logic [3:0] maske;
        void'($urandom(32'h07fc_b9ad));
        rst_n_i = 1'b0;
        bib_adr_i = '0;
        bib_veri_i = '0;
        bib_maske_i = '0;
        bib_sec_i = 1'b0;
        foreach (golge_pwm[i]) golge_pwm[i] = '0;
        repeat (2) @(posedge clk);
        #(SURUS_NS);
        rst_n_i = 1'b1;

        pwm_olc(20, 0, 0); // Registers still zero.
        test_bitir("pwm idle");

        repeat (64) begin
            idx = int'($urandom_range(255, 0));
            maske = yazildi[idx] ? 4'($urandom_range(15, 1)) : 4'hf; // First write fills.
            yaz(L1V_TABAN | (32'(idx) << 2), $urandom, maske);
            yazildi[idx] = 1'b1;
        end
        for (int i = 0; i < 256; i++) begin
            if (yazildi[i]) oku(L1V_TABAN | (32'(i) << 2));
        end
        test_bitir("scratchpad");

        oku(TMR_TABAN);
        oku(TMR_TABAN | 32'h4);
        repeat (13) @(posedge clk);
        #(SURUS_NS);
        oku(TMR_TABAN);
        oku(TMR_TABAN | 32'h4);
        oku(32'h3000_0000); // Timer wins over PWM.
        test_bitir("timer");

        for (int r = 0; r < 3; r++) begin
            yaz(VY_TABAN | 32'(r * 4), $urandom, 4'hf);
            yaz(VY_TABAN | 32'(r * 4), $urandom, 4'($urandom_range(15, 1)));
        end
        for (int r = 0; r < 4; r++) begin
            oku(VY_TABAN | 32'(r * 4));
        end
        test_bitir("pwm registers");

        yaz(VY_TABAN, 32'(PWM_P), 4'b0011);
        yaz(VY_TABAN | 32'h4, 32'd3, 4'b0011);
        yaz(VY_TABAN | 32'h8, 32'd14, 4'b0011);
        bek0 = (golge_pwm[1] < golge_pwm[0]) ? int'(golge_pwm[1]) : int'(golge_pwm[0]);
        bek1 = (golge_pwm[2] < golge_pwm[0]) ? int'(golge_pwm[2]) : int'(golge_pwm[0]);
        repeat (2 * PWM_P) @(posedge clk);
        #(SURUS_NS);
        pwm_olc(PWM_P, bek0, bek1);
        test_bitir("pwm outputs");

        yaz(L1V_TABAN | 32'h8, 32'hcafe_f00d, 4'hf);
        oku(32'h0000_0010);
        yaz(32'h0000_0008, 32'h1234_5678, 4'hf); // Must land nowhere.
        oku(32'h8000_0004);
        oku(L1V_TABAN | 32'h8);
        oku(32'h5000_0008);
        yaz(32'h5000_000c, 32'h0bad_beef, 4'hf);
        oku(L1V_TABAN | 32'hc);
        oku(VY_TABAN | 32'h8);
        test_bitir("unmapped and priority");

        ihlal = dut0.bib_yonlendirici0.bib_chk0.ihlal_say;
        $display("checks %0d, errors %0d, assertion failures %0d", kontrol_say, hata_say, ihlal);
        if (hata_say == 0 && ihlal == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* project.f */
src/adres_haritasi_pkg.sv
src/cevre_pkg.sv
src/bib_yonlendirici.sv
src/veri_bellegi.sv
src/zamanlayici.sv
src/darbe_genislik.sv
src/cekirdek_ramsiz.sv
bench/bib_chk.sv
bench/tb_cekirdek_ramsiz.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cekirdek_ramsiz
FLIST    = project.f
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
